//--- aluPort.sv
`timescale 1ns/1ps
interface aluPort;

    cpuTypesPkg::aluOpT opSelect;
    logic               start;      // one-cycle pulse that samples the operands
    cpuTypesPkg::wordT  operandA;   // register Y
    cpuTypesPkg::wordT  operandB;   // live bus value
    cpuTypesPkg::wordT  resultLo;
    cpuTypesPkg::wordT  resultHi;
    logic               finished;   // one-cycle pulse with results held until next start

    // bus register side
    modport issuer (
        output opSelect, start, operandA, operandB,
        input  resultLo, resultHi, finished
    );

    // alu side
    modport executor (
        input  opSelect, start, operandA, operandB,
        output resultLo, resultHi, finished
    );

endinterface

//--- aluUnit.sv
`timescale 1ns/1ps
module aluUnit (
    input logic      Clock,
    input logic      reset,
    aluPort.executor alu
);
    import cpuTypesPkg::*;

    logic                      busy;
    logic [stepCountWidth-1:0] stepCount;
    aluOpT                     activeOp;
    wordT                      opndA, opndB;   // operands captured at start
    wordT                      accHi, accLo;   // shared mul/div working pair
    logic                      startMulDiv;
    logic [4:0]                shAmt;
    logic [2*dataWidth-1:0]    rotWide, rotRight, rotLeft;
    wordT                      singleResult;
    wordT                      startDividendMag;
    logic [dataWidth:0]        mulSum;
    wordT                      mulHi, mulLo;
    wordT                      divisorMag;
    logic [dataWidth:0]        divShifted, divDiff;
    logic                      quoBit;
    wordT                      divRem, divQuo;
    wordT                      finalLo, finalHi;

    assign startMulDiv = (alu.opSelect == aluMul) || (alu.opSelect == aluDiv);

    // single-cycle operations straight from the operands
    always_comb begin
        shAmt    = alu.operandB[4:0];
        rotWide  = {alu.operandA, alu.operandA};
        rotRight = rotWide >> shAmt;
        rotLeft  = rotWide << shAmt;
        case (alu.opSelect)
            aluAdd:  singleResult = alu.operandA + alu.operandB;
            aluSub:  singleResult = alu.operandA - alu.operandB;
            aluAnd:  singleResult = alu.operandA & alu.operandB;
            aluOr:   singleResult = alu.operandA | alu.operandB;
            aluShr:  singleResult = alu.operandA >> shAmt;
            aluShra: singleResult = wordT'($signed(alu.operandA) >>> shAmt);
            aluShl:  singleResult = alu.operandA << shAmt;
            aluRor:  singleResult = rotRight[dataWidth-1:0];
            aluRol:  singleResult = rotLeft[2*dataWidth-1:dataWidth];
            aluNeg:  singleResult = -alu.operandB;   // unary ops take the bus operand
            aluNot:  singleResult = ~alu.operandB;
            default: singleResult = '0;
        endcase
    end

    assign startDividendMag = alu.operandA[dataWidth-1] ? -alu.operandA : alu.operandA;

    // one shift-add step with the multiplier draining out the bottom of accLo
    always_comb begin
        mulSum = {1'b0, accHi} + (accLo[0] ? {1'b0, opndA} : '0);
        mulHi  = mulSum[dataWidth:1];
        mulLo  = {mulSum[0], accLo[dataWidth-1:1]};
    end

    // one restoring division step on magnitudes
    always_comb begin
        divisorMag = opndB[dataWidth-1] ? -opndB : opndB;
        divShifted = {accHi, accLo[dataWidth-1]};
        divDiff    = divShifted - {1'b0, divisorMag};
        quoBit     = !divDiff[dataWidth];   // no borrow means it fits
        divRem     = quoBit ? divDiff[dataWidth-1:0] : divShifted[dataWidth-1:0];
        divQuo     = {accLo[dataWidth-2:0], quoBit};
    end

    // sign fix-up applied on the last step
    always_comb begin
        if (activeOp == aluMul) begin
            // unsigned product minus the two sign-bit cross terms
            finalLo = mulLo;
            finalHi = mulHi - (opndA[dataWidth-1] ? opndB : '0)
                            - (opndB[dataWidth-1] ? opndA : '0);
        end else if (opndB == '0) begin
            finalLo = '1;      // divide by zero
            finalHi = opndA;
        end else begin
            finalLo = (opndA[dataWidth-1] ^ opndB[dataWidth-1]) ? -divQuo : divQuo;
            finalHi = opndA[dataWidth-1] ? -divRem : divRem;   // follows the dividend
        end
    end

    // control and results
    always_ff @(posedge Clock) begin
        if (reset) begin
            busy         <= 1'b0;
            stepCount    <= '0;
            alu.finished <= 1'b0;
            alu.resultLo <= '0;
            alu.resultHi <= '0;
        end else begin
            alu.finished <= 1'b0;
            if (busy) begin
                stepCount <= stepCount + 1'b1;
                if (stepCount == stepCountWidth'(mulDivSteps - 1)) begin
                    busy         <= 1'b0;
                    alu.finished <= 1'b1;
                    alu.resultLo <= finalLo;
                    alu.resultHi <= finalHi;
                end
            end else if (alu.start) begin
                if (startMulDiv) begin
                    busy      <= 1'b1;
                    stepCount <= '0;
                end else begin
                    alu.finished <= 1'b1;   // visible the cycle after start
                    alu.resultLo <= singleResult;
                    alu.resultHi <= '0;
                end
            end
        end
    end

    // working registers
    always_ff @(posedge Clock) begin
        if (busy) begin
            accHi <= (activeOp == aluMul) ? mulHi : divRem;
            accLo <= (activeOp == aluMul) ? mulLo : divQuo;
        end else if (alu.start) begin
            activeOp <= alu.opSelect;
            opndA    <= alu.operandA;
            opndB    <= alu.operandB;
            accHi    <= '0;
            accLo    <= (alu.opSelect == aluDiv) ? startDividendMag : alu.operandB;
        end
    end

    // the issuer has no busy view and must wait for finished
    startWhileBusy: assert property (
        @(posedge Clock) disable iff (reset)
        alu.start |-> !busy
    ) else $error("aluUnit: start raised while a multiply/divide is running");

    finishedPulse: assert property (
        @(posedge Clock) disable iff (reset)
        alu.finished |=> !alu.finished
    ) else $error("aluUnit: finished held longer than one cycle");

endmodule

//--- busPkg.sv
package busPkg;

    // general register number sized from the register count
    typedef logic [$clog2(cpuTypesPkg::numRegs)-1:0] regIndexT;

    // which block drives the shared bus this cycle
    typedef enum logic [3:0] {
        srcNone,   // bus reads zero when nothing is selected
        srcReg,    // general register picked by rfSelect
        srcPc,
        srcIr,
        srcY,
        srcZLo,
        srcZHi,
        srcMar,
        srcHi,
        srcLo,
        srcMdr
    } busSrcT;

endpackage

//--- busRegisters.sv
`timescale 1ns/1ps
module busRegisters (
    input  logic               Clock,
    input  logic               reset,
    // bus source strobes
    input  logic               rfOut,
    input  logic               pcOut,
    input  logic               irOut,
    input  logic               yOut,
    input  logic               zLoOut,
    input  logic               zHiOut,
    input  logic               marOut,
    input  logic               hiOut,
    input  logic               loOut,
    input  logic               mdrOut,
    // load strobes for the special registers
    input  logic               pcIn,
    input  logic               irIn,
    input  logic               yIn,
    input  logic               zIn,
    input  logic               marIn,
    input  logic               hiIn,
    input  logic               loIn,
    input  logic               mdrIn,
    input  logic               read,
    input  cpuTypesPkg::wordT  memDataIn,
    input  logic               start,
    input  cpuTypesPkg::aluOpT opSelect,
    input  cpuTypesPkg::wordT  readData,    // selected general register
    aluPort.issuer             alu,
    output cpuTypesPkg::wordT  busValue,
    output cpuTypesPkg::wordT  memAddress,
    output logic               finished
);
    import cpuTypesPkg::*;
    import busPkg::*;

    wordT   pcReg, irReg, yReg, zLoReg, zHiReg, marReg, hiReg, loReg, mdrReg;
    busSrcT busSrc;

    always_ff @(posedge Clock) begin
        if (reset) begin
            pcReg  <= '0;
            irReg  <= '0;
            yReg   <= '0;
            zLoReg <= '0;
            zHiReg <= '0;
            marReg <= '0;
            hiReg  <= '0;
            loReg  <= '0;
            mdrReg <= '0;
        end else begin
            if (pcIn)  pcReg  <= busValue;
            if (irIn)  irReg  <= busValue;
            if (yIn)   yReg   <= busValue;
            if (marIn) marReg <= busValue;
            if (hiIn)  hiReg  <= busValue;
            if (loIn)  loReg  <= busValue;
            if (zIn) begin
                zLoReg <= alu.resultLo;   // Z only ever loads from the alu
                zHiReg <= alu.resultHi;
            end
            if (mdrIn) mdrReg <= read ? memDataIn : busValue;
        end
    end

    // strobes to a single source code
    always_comb begin
        if (rfOut)       busSrc = srcReg;
        else if (pcOut)  busSrc = srcPc;
        else if (irOut)  busSrc = srcIr;
        else if (yOut)   busSrc = srcY;
        else if (zLoOut) busSrc = srcZLo;
        else if (zHiOut) busSrc = srcZHi;
        else if (marOut) busSrc = srcMar;
        else if (hiOut)  busSrc = srcHi;
        else if (loOut)  busSrc = srcLo;
        else if (mdrOut) busSrc = srcMdr;
        else             busSrc = srcNone;
    end

    always_comb begin
        case (busSrc)
            srcReg:  busValue = readData;
            srcPc:   busValue = pcReg;
            srcIr:   busValue = irReg;
            srcY:    busValue = yReg;
            srcZLo:  busValue = zLoReg;
            srcZHi:  busValue = zHiReg;
            srcMar:  busValue = marReg;
            srcHi:   busValue = hiReg;
            srcLo:   busValue = loReg;
            srcMdr:  busValue = mdrReg;
            default: busValue = '0;   // idle bus
        endcase
    end

    // alu sees Y and whatever is on the bus during the start cycle
    assign alu.opSelect = opSelect;
    assign alu.start    = start;
    assign alu.operandA = yReg;
    assign alu.operandB = busValue;

    assign finished   = alu.finished;
    assign memAddress = marReg;

    // the priority chain above would hide a second driver
    oneBusSource: assert property (
        @(posedge Clock) disable iff (reset)
        $onehot0({rfOut, pcOut, irOut, yOut, zLoOut, zHiOut, marOut, hiOut, loOut, mdrOut})
    ) else $error("busRegisters: more than one out strobe active");

endmodule

//--- clockGen.sv
`timescale 1ns/1ps
module clockGen (
    output logic Clock,
    output logic reset
);

    initial begin
        Clock = 1'b0;
        forever #4 Clock = ~Clock;   // 8 ns period
    end

    // reset held high for the first 8 rising edges
    initial begin
        reset = 1'b1;
        repeat (8) @(posedge Clock);
        reset <= 1'b0;
    end

endmodule

//--- compile.f
cpuTypesPkg.sv
busPkg.sv
aluPort.sv
registerFile.sv
aluUnit.sv
busRegisters.sv
dataPath.sv
clockGen.sv
dataPathTb.sv

//--- cpuTypesPkg.sv
package cpuTypesPkg;

    // datapath geometry
    localparam int dataWidth = 32;   // bus and register width
    localparam int numRegs   = 16;   // general registers R0..R15

    // iterative multiply/divide
    localparam int mulDivSteps    = 32;   // one step per operand bit
    localparam int stepCountWidth = $clog2(mulDivSteps + 1);

    typedef logic [dataWidth-1:0] wordT;

    // alu operation codes
    typedef enum logic [4:0] {
        aluAdd  = 5'b00000,
        aluSub  = 5'b00001,
        aluAnd  = 5'b00010,
        aluOr   = 5'b00011,
        aluShr  = 5'b00100,   // logical right
        aluShra = 5'b00101,   // arithmetic right
        aluShl  = 5'b00110,
        aluRol  = 5'b00111,
        aluNeg  = 5'b01000,
        aluNot  = 5'b01001,
        aluMul  = 5'b01010,   // multi-cycle
        aluDiv  = 5'b01011,   // multi-cycle
        aluRor  = 5'b11011
    } aluOpT;

endpackage

//--- dataPath.sv
`timescale 1ns/1ps
module dataPath (
    input  logic               Clock,
    input  logic               reset,
    input  logic               rfOut,
    input  logic               pcOut,
    input  logic               irOut,
    input  logic               yOut,
    input  logic               zLoOut,
    input  logic               zHiOut,
    input  logic               marOut,
    input  logic               hiOut,
    input  logic               loOut,
    input  logic               mdrOut,
    input  logic               rfIn,
    input  logic               pcIn,
    input  logic               irIn,
    input  logic               yIn,
    input  logic               zIn,
    input  logic               marIn,
    input  logic               hiIn,
    input  logic               loIn,
    input  logic               mdrIn,
    input  logic               read,
    input  busPkg::regIndexT   rfSelect,
    input  cpuTypesPkg::wordT  memDataIn,   // memory read data
    input  cpuTypesPkg::aluOpT opSelect,
    input  logic               start,
    output logic               finished,
    output cpuTypesPkg::wordT  busValue,
    output cpuTypesPkg::wordT  memAddress   // from MAR
);
    import cpuTypesPkg::*;

    wordT readData;   // general register onto the bus mux

    aluPort aluLink ();

    registerFile regFile (
        .Clock    (Clock),
        .reset    (reset),
        .rfSelect (rfSelect),
        .rfIn     (rfIn),
        .busValue (busValue),
        .readData (readData)
    );

    aluUnit alu (
        .Clock (Clock),
        .reset (reset),
        .alu   (aluLink.executor)
    );

    busRegisters busRegs (
        .Clock      (Clock),
        .reset      (reset),
        .rfOut      (rfOut),
        .pcOut      (pcOut),
        .irOut      (irOut),
        .yOut       (yOut),
        .zLoOut     (zLoOut),
        .zHiOut     (zHiOut),
        .marOut     (marOut),
        .hiOut      (hiOut),
        .loOut      (loOut),
        .mdrOut     (mdrOut),
        .pcIn       (pcIn),
        .irIn       (irIn),
        .yIn        (yIn),
        .zIn        (zIn),
        .marIn      (marIn),
        .hiIn       (hiIn),
        .loIn       (loIn),
        .mdrIn      (mdrIn),
        .read       (read),
        .memDataIn  (memDataIn),
        .start      (start),
        .opSelect   (opSelect),
        .readData   (readData),
        .alu        (aluLink.issuer),
        .busValue   (busValue),
        .memAddress (memAddress),
        .finished   (finished)
    );

endmodule

//--- dataPathTb.sv
`timescale 1ns/1ps
module dataPathTb;
    import cpuTypesPkg::*;

    logic Clock, reset;
    logic rfOut, pcOut, irOut, yOut, zLoOut, zHiOut, marOut, hiOut, loOut, mdrOut;
    logic rfIn, pcIn, irIn, yIn, zIn, marIn, hiIn, loIn, mdrIn, read, start, finished;
    busPkg::regIndexT rfSelect;
    wordT  memDataIn, busValue, memAddress;
    aluOpT opSelect;

    int errorCount = 0, errorsAtStart = 0, checkCount = 0, passCount = 0, failCount = 0;

    aluOpT singleOps [11] = '{aluAdd, aluSub, aluAnd, aluOr, aluShr, aluShra, aluShl,
                              aluRor, aluRol, aluNeg, aluNot};

    clockGen clkGen (.Clock(Clock), .reset(reset));

    dataPath uut (.*);

    task automatic stepCycle();
        @(posedge Clock);
        #1;   // inputs change just after the edge
    endtask

    task automatic setOut(input busPkg::busSrcT src, input logic on);
        case (src)
            busPkg::srcReg: rfOut  = on;
            busPkg::srcPc:  pcOut  = on;
            busPkg::srcIr:  irOut  = on;
            busPkg::srcY:   yOut   = on;
            busPkg::srcZLo: zLoOut = on;
            busPkg::srcZHi: zHiOut = on;
            busPkg::srcMar: marOut = on;
            busPkg::srcHi:  hiOut  = on;
            busPkg::srcLo:  loOut  = on;
            busPkg::srcMdr: mdrOut = on;
            default: ;
        endcase
    endtask

    task automatic setIn(input busPkg::busSrcT dst, input logic on);
        case (dst)
            busPkg::srcReg: rfIn  = on;
            busPkg::srcPc:  pcIn  = on;
            busPkg::srcIr:  irIn  = on;
            busPkg::srcY:   yIn   = on;
            busPkg::srcMar: marIn = on;
            busPkg::srcHi:  hiIn  = on;
            busPkg::srcLo:  loIn  = on;
            busPkg::srcMdr: mdrIn = on;
            default: ;
        endcase
    endtask

    task automatic checkWord(input wordT actual, input wordT expected, input string what);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("** Error at %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    // memory read into MDR like a load instruction
    task automatic loadMdr(input wordT value);
        memDataIn = value;
        read      = 1'b1;
        mdrIn     = 1'b1;
        stepCycle();
        read  = 1'b0;
        mdrIn = 1'b0;
    endtask

    // one bus transfer with idx selecting the general register on whichever side uses it
    task automatic move(input busPkg::busSrcT src, input busPkg::busSrcT dst, input int idx);
        rfSelect = idx[3:0];
        setOut(src, 1'b1);
        setIn(dst, 1'b1);
        stepCycle();
        setOut(src, 1'b0);
        setIn(dst, 1'b0);
    endtask

    task automatic expectBus(input busPkg::busSrcT src, input int idx, input wordT expected,
                             input string what);
        rfSelect = idx[3:0];
        setOut(src, 1'b1);
        #2;   // bus mux has settled well before the next edge
        checkWord(busValue, expected, what);
        stepCycle();
        setOut(src, 1'b0);
    endtask

    // start with operand B on the bus, wait for finished, then capture Z
    task automatic runAlu(input aluOpT op, input busPkg::busSrcT bSrc, input int idx);
        int n;
        n        = 0;
        opSelect = op;
        rfSelect = idx[3:0];
        start    = 1'b1;
        setOut(bSrc, 1'b1);
        stepCycle();
        start = 1'b0;
        setOut(bSrc, 1'b0);
        while (finished !== 1'b1 && n < 100) begin
            stepCycle();
            n++;
        end
        if (finished !== 1'b1) begin
            errorCount++;
            $display("timeout: %s never raised finished within 100 cycles", op.name());
        end
        zIn = 1'b1;
        stepCycle();
        zIn = 1'b0;
    endtask

    function automatic wordT singleModel(input aluOpT op, input wordT a, input wordT b);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            aluAdd:  return a + b;
            aluSub:  return a - b;
            aluAnd:  return a & b;
            aluOr:   return a | b;
            aluShr:  return a >> sh;
            aluShra: return (a >> sh) | ({32{a[31]}} << (32 - sh));   // sign fills the top
            aluShl:  return a << sh;
            aluRor:  return (a >> sh) | (a << (32 - sh));   // shift by 32 drops to zero
            aluRol:  return (a << sh) | (a >> (32 - sh));
            aluNeg:  return -b;
            aluNot:  return ~b;
            default: return '0;
        endcase
    endfunction

    task automatic reportTest(input string name);
        if (errorCount == errorsAtStart) begin
            passCount++;
            $display("PASS  %s", name);
        end else begin
            failCount++;
            $display("FAIL  %s (%0d errors)", name, errorCount - errorsAtStart);
        end
        errorsAtStart = errorCount;
    endtask

    task automatic resetAndLoads();
        wordT vals [3];
        for (int k = 1; k <= 10; k++) begin
            expectBus(busPkg::busSrcT'(k), 0, '0, $sformatf("source %0d after reset", k));
        end
        for (int r = 1; r <= 3; r++) begin
            vals[r-1] = $urandom;
            loadMdr(vals[r-1]);
            move(busPkg::srcMdr, busPkg::srcReg, r);
        end
        for (int r = 1; r <= 3; r++) begin
            expectBus(busPkg::srcReg, r, vals[r-1], $sformatf("R%0d", r));
        end
    endtask

    task automatic referenceRotate();
        loadMdr(32'hABC00012);
        move(busPkg::srcMdr, busPkg::srcReg, 2);
        loadMdr(32'h00000008);
        move(busPkg::srcMdr, busPkg::srcReg, 3);
        move(busPkg::srcReg, busPkg::srcY, 2);
        runAlu(aluRor, busPkg::srcReg, 3);
        move(busPkg::srcZLo, busPkg::srcReg, 1);
        expectBus(busPkg::srcReg, 1, 32'h12ABC000, "R1 after ror");
    endtask

    task automatic singleStepOps();
        wordT a, b;
        for (int i = 0; i < 20; i++) begin
            a = $urandom;
            b = $urandom;
            loadMdr(a);
            move(busPkg::srcMdr, busPkg::srcY, 0);
            loadMdr(b);   // MDR stays as operand B for every op
            foreach (singleOps[j]) begin
                runAlu(singleOps[j], busPkg::srcMdr, 0);
                expectBus(busPkg::srcZLo, 0, singleModel(singleOps[j], a, b),
                          $sformatf("ZLo for %s", singleOps[j].name()));
            end
        end
    endtask

    task automatic mulDivOps();
        wordT a, b, bMag, quo, rem;
        logic signed [63:0] sa, sb, prod, sq, sr;
        for (int i = 0; i < 10; i++) begin
            a     = $urandom;
            a[31] = i[0];   // dividend sign alternates
            bMag  = $urandom >> (i + 1);
            b     = (i == 9) ? '0 : (i[1] ? -bMag : bMag);   // last pass divides by zero
            sa = {{32{a[31]}}, a};
            sb = {{32{b[31]}}, b};
            prod = sa * sb;
            if (b == '0) begin
                quo = '1;
                rem = a;
            end else begin
                sq  = sa / sb;   // truncates toward zero
                sr  = sa % sb;   // sign follows the dividend
                quo = sq[31:0];
                rem = sr[31:0];
            end
            loadMdr(a);
            move(busPkg::srcMdr, busPkg::srcY, 0);
            loadMdr(b);
            runAlu(aluMul, busPkg::srcMdr, 0);
            expectBus(busPkg::srcZLo, 0, prod[31:0], "product low");
            expectBus(busPkg::srcZHi, 0, prod[63:32], "product high");
            runAlu(aluDiv, busPkg::srcMdr, 0);
            expectBus(busPkg::srcZLo, 0, quo, "quotient");
            expectBus(busPkg::srcZHi, 0, rem, "remainder");
            move(busPkg::srcZHi, busPkg::srcHi, 0);
            move(busPkg::srcZLo, busPkg::srcLo, 0);
            expectBus(busPkg::srcHi, 0, rem, "HI");
            expectBus(busPkg::srcLo, 0, quo, "LO");
        end
    endtask

    task automatic specialPaths();
        busPkg::busSrcT dsts [5] = '{busPkg::srcPc, busPkg::srcIr, busPkg::srcMar,
                                     busPkg::srcHi, busPkg::srcLo};
        wordT v;
        foreach (dsts[k]) begin
            v = $urandom;
            loadMdr(v);
            move(busPkg::srcMdr, dsts[k], 0);
            expectBus(dsts[k], 0, v, dsts[k].name());
            if (dsts[k] == busPkg::srcMar) begin
                checkWord(memAddress, v, "memAddress");
            end
        end
    endtask

    initial begin
        int n;
        {rfOut, pcOut, irOut, yOut, zLoOut, zHiOut, marOut, hiOut, loOut, mdrOut} = '0;
        {rfIn, pcIn, irIn, yIn, zIn, marIn, hiIn, loIn, mdrIn, read, start} = '0;
        rfSelect  = '0;
        memDataIn = '0;
        opSelect  = aluAdd;
        void'($urandom(23845));
        n = 0;
        do begin
            stepCycle();
            n++;
        end while (reset !== 1'b0 && n < 100);
        if (reset !== 1'b0) begin
            errorCount++;
            $display("timeout: reset was never released");
        end
        resetAndLoads();
        reportTest("reset and register loads");
        referenceRotate();
        reportTest("reference rotate");
        singleStepOps();
        reportTest("single-step operations");
        mulDivOps();
        reportTest("multiply and divide");
        specialPaths();
        reportTest("special register paths");
        $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
                 passCount, failCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- registerFile.sv
`timescale 1ns/1ps
module registerFile (
    input  logic              Clock,
    input  logic              reset,
    input  busPkg::regIndexT  rfSelect,
    input  logic              rfIn,       // write strobe loading from the bus
    input  cpuTypesPkg::wordT busValue,
    output cpuTypesPkg::wordT readData
);
    import cpuTypesPkg::*;
    import busPkg::*;

    wordT regs [numRegs];

    always_ff @(posedge Clock) begin
        if (reset) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (rfIn) begin
            regs[rfSelect] <= busValue;
        end
    end

    // the read port shares the selector so a write shows up next cycle
    assign readData = regs[rfSelect];

    // a write with a floating selector would corrupt an unknown register
    rfSelectKnown: assert property (
        @(posedge Clock) disable iff (reset)
        rfIn |-> !$isunknown(rfSelect)
    ) else $error("registerFile: write with unknown rfSelect");

endmodule
